// ==== filelist.f ====
+incdir+source
source/mshr_pkg.sv
source/mshr_alloc_ctrl.sv
source/mshr_phase_issuer.sv
source/mshr_req_build.sv
source/mshr_entry_top.sv
dv/mshr_entry_assert.sv
dv/mshr_entry_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the MSHR entry testbench, then scan the log
LOG=sim.log
verilator --binary --timing --assert -f filelist.f --top-module mshr_entry_tb \
    -o mshr_entry_sim || exit 1
./obj_dir/mshr_entry_sim > "$LOG" 2>&1 || echo "FAIL: see errors above" >> "$LOG"
cat "$LOG"
grep -q "FAIL: see errors above" "$LOG" && exit 1
grep -q "PASS: all tests" "$LOG" || exit 1
exit 0

// ==== dv/mshr_entry_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mshr_macros.svh"

module mshr_entry_tb
    import mshr_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_ROWS     = 7;
    localparam int ROW_CYCLES   = 200;

    typedef struct packed {
        logic                        need_evict;
        logic                        need_linefill;
        logic                        is_read;
        logic                        is_write;
        logic                        hzd_pass;
        logic [`MSHR_ENTRY_NUM-1:0]  hzd_bitmap;
        logic [7:0]                  rel_cycle;
        logic [`TAG_WIDTH-1:0]       tag;
        logic [`INDEX_WIDTH-1:0]     index;
        logic [`WAY_WIDTH-1:0]       way;
        logic [`ALLOC_IDX_WIDTH-1:0] alloc_idx;
        logic [`DB_ID_WIDTH-1:0]     wdb_id;
        logic [2:0]                  exp_evict;
        logic [1:0]                  exp_fill;
        logic [1:0]                  exp_access;
        logic [`OPCODE_WIDTH-1:0]    exp_op;
    } row_t;

    logic                       clk;
    logic                       rst_n;
    logic                       alloc_vld;
    logic                       alloc_rdy;
    mshr_alloc_t                alloc_pld;
    logic [`MSHR_ENTRY_NUM-1:0] v_release_en;
    logic                       release_en;
    logic                       entry_active;
    logic                       evict_vld;
    logic                       evict_rdy;
    dataram_req_t               evict_pld;
    logic                       evict_clean;
    logic                       ds_req_vld;
    logic                       ds_req_rdy;
    ds_req_t                    ds_req_pld;
    logic                       linefill_done;
    logic                       dataram_vld;
    logic                       dataram_rdy;
    dataram_req_t               dataram_pld;
    logic                       access_done;

    // responder channels, 0 evict, 1 linefill, 2 access
    logic [2:0] chan_vld;
    logic [2:0] chan_last;
    logic [2:0] chan_rdy  = '0;
    logic [2:0] chan_done = '0;
    int         done_wait [3];
    integer     seed = 24;

    row_t                       rows  [NUM_ROWS];
    string                      names [NUM_ROWS];
    string                      cur_name = "reset";
    mshr_alloc_t                cur = '0;
    logic [`MSHR_ENTRY_NUM-1:0] deps_left = '0;
    logic                       clean_seen = 1'b0;
    logic                       fill_seen = 1'b0;
    int                         n_evict = 0;
    int                         n_fill = 0;
    int                         n_access = 0;
    int                         n_release = 0;
    int                         access_op = -1;
    int                         access_db = -1;
    int                         err_count = 0;

    mshr_entry_top u_dut (.*);

    assign chan_vld      = {dataram_vld, ds_req_vld, evict_vld};
    assign chan_last     = {1'b1, 1'b1, evict_pld.last};
    assign evict_rdy     = chan_rdy[0];
    assign ds_req_rdy    = chan_rdy[1];
    assign dataram_rdy   = chan_rdy[2];
    assign evict_clean   = chan_done[0];
    assign linefill_done = chan_done[1];
    assign access_done   = chan_done[2];

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_mismatch(input string what, input int expected, input int actual);
        $display("error %s: %s expected %0d actual %0d", cur_name, what, expected, actual);
        err_count++;
    endtask

    task automatic report_problem(input string what);
        $display("%s: %s", cur_name, what);
        err_count++;
    endtask

    // ====================
    // test table
    // ====================
    function automatic void load_table();
        // evict fill rd wr pass bitmap rel, tag index way idx wdb, beats fills accs op
        names[0] = "rd_hit";
        rows[0]  = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 8'h00, 8'd0,
                     20'hA5F31, 8'h12, 3'd2, 3'd1, 5'h00, 3'd0, 2'd0, 2'd1, `OP_READ};
        names[1] = "wr_hit";
        rows[1]  = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 8'h00, 8'd0,
                     20'h3C0DE, 8'h47, 3'd5, 3'd2, 5'h13, 3'd0, 2'd0, 2'd1, `OP_WRITE};
        names[2] = "rd_fill";
        rows[2]  = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 8'h00, 8'd0,
                     20'hF1234, 8'h80, 3'd0, 3'd3, 5'h00, 3'd0, 2'd1, 2'd1, `OP_READ};
        names[3] = "wr_evict_fill";
        rows[3]  = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 8'h00, 8'd0,
                     20'h8BEEF, 8'h3A, 3'd7, 3'd4, 5'h1D, 3'd4, 2'd1, 2'd1, `OP_WRITE};
        names[4] = "rd_hzd_one";
        rows[4]  = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 8'h04, 8'd5,
                     20'h52A6C, 8'hC5, 3'd1, 3'd5, 5'h00, 3'd4, 2'd1, 2'd1, `OP_READ};
        names[5] = "wr_hzd_two";
        rows[5]  = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 8'h81, 8'd3,
                     20'hE0077, 8'hFE, 3'd6, 3'd6, 5'h0A, 3'd0, 2'd1, 2'd1, `OP_WRITE};
        names[6] = "rd_evict";
        rows[6]  = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 8'h00, 8'd0,
                     20'h0F00F, 8'h01, 3'd3, 3'd7, 5'h00, 3'd4, 2'd0, 2'd1, `OP_READ};
    endfunction

    // random back-pressure, completion 1 to 3 cycles after the last beat
    always @(posedge clk or negedge rst_n) begin
        int ch;
        if (!rst_n) begin
            chan_rdy  <= '0;
            chan_done <= '0;
        end else begin
            for (ch = 0; ch < 3; ch++) begin
                chan_rdy[ch]  <= (($random(seed) & 3) != 0);
                chan_done[ch] <= (done_wait[ch] == 1);
                if (chan_vld[ch] && chan_rdy[ch] && chan_last[ch]) begin
                    done_wait[ch] <= 1 + ({$random(seed)} % 3);
                end else if (done_wait[ch] > 0) begin
                    done_wait[ch] <= done_wait[ch] - 1;
                end
            end
        end
    end

    // ====================
    // monitor
    // ====================
    always @(posedge clk) begin
        if (rst_n) begin
            if ((evict_vld || ds_req_vld || dataram_vld) && deps_left != '0) begin
                report_problem("request issued before the hazard bitmap cleared");
            end
            if (alloc_vld && alloc_rdy) begin
                cur        = alloc_pld;
                deps_left  = alloc_pld.hzd_pass ? '0 : alloc_pld.hzd_bitmap;
                n_evict    = 0;
                n_fill     = 0;
                n_access   = 0;
                clean_seen = 1'b0;
                fill_seen  = 1'b0;
                access_op  = -1;
                access_db  = -1;
            end else begin
                deps_left = deps_left & ~v_release_en;
            end
            if (evict_vld && evict_rdy) begin
                if (int'(evict_pld.txnid.byte_sel) != n_evict) begin
                    report_mismatch("evict byte select", n_evict,
                                    int'(evict_pld.txnid.byte_sel));
                end
                if (evict_pld.last != (n_evict == `EVICT_BEATS - 1)) begin
                    report_mismatch("evict last", int'(n_evict == `EVICT_BEATS - 1),
                                    int'(evict_pld.last));
                end
                if (int'(evict_pld.db_entry_id) != int'({cur.alloc_idx, 2'(n_evict)})) begin
                    report_mismatch("evict buffer id", int'({cur.alloc_idx, 2'(n_evict)}),
                                    int'(evict_pld.db_entry_id));
                end
                // destination ram is the top of the tag
                if (evict_pld.dest_ram_id != cur.tag[`TAG_WIDTH-1 -: `DEST_RAM_BITS]) begin
                    report_mismatch("evict dest ram",
                                    int'(cur.tag[`TAG_WIDTH-1 -: `DEST_RAM_BITS]),
                                    int'(evict_pld.dest_ram_id));
                end
                n_evict++;
            end
            if (ds_req_vld && ds_req_rdy) begin
                if (cur.need_evict && !clean_seen) begin
                    report_problem("linefill request transferred before evict_clean");
                end
                if (ds_req_pld.addr.tag != cur.tag) begin
                    report_mismatch("linefill tag", int'(cur.tag),
                                    int'(ds_req_pld.addr.tag));
                end
                // linefill buffer is the entry's own, beat bits zero
                if (int'(ds_req_pld.db_entry_id) != int'({cur.alloc_idx, 2'b00})) begin
                    report_mismatch("linefill buffer id", int'({cur.alloc_idx, 2'b00}),
                                    int'(ds_req_pld.db_entry_id));
                end
                n_fill++;
            end
            if (dataram_vld && dataram_rdy) begin
                if (cur.need_evict && !clean_seen) begin
                    report_problem("access request transferred before evict_clean");
                end
                if (cur.need_linefill && !fill_seen) begin
                    report_problem("access request transferred before linefill_done");
                end
                access_op = int'(dataram_pld.opcode);
                access_db = int'(dataram_pld.db_entry_id);
                n_access++;
            end
            if (evict_clean) begin
                clean_seen = 1'b1;
            end
            if (linefill_done) begin
                fill_seen = 1'b1;
            end
            if (release_en) begin
                n_release++;
            end
        end
    end

    // one allocation through to its release
    task automatic run_row(input int r);
        mshr_alloc_t                p;
        logic [`MSHR_ENTRY_NUM-1:0] pend;
        logic [`MSHR_ENTRY_NUM-1:0] low;
        logic [`DB_ID_WIDTH-1:0]    exp_db;
        int                         cyc;

        cur_name = names[r];
        p = '0;
        p.txnid.direction_id = 2'(r);
        p.txnid.master_id    = 4'(r + 5);
        p.txnid.mode         = 2'd1;
        p.tag                = rows[r].tag;
        p.index              = rows[r].index;
        p.offset             = 2'(r);
        p.way                = rows[r].way;
        p.alloc_idx          = rows[r].alloc_idx;
        p.wdb_entry_id       = rows[r].wdb_id;
        p.sideband           = 8'(r * 37 + 11);
        p.hit                = ~rows[r].need_linefill;
        p.need_evict         = rows[r].need_evict;
        p.need_linefill      = rows[r].need_linefill;
        p.is_read            = rows[r].is_read;
        p.is_write           = rows[r].is_write;
        p.hzd_pass           = rows[r].hzd_pass;
        p.hzd_bitmap         = rows[r].hzd_bitmap;
        @(posedge clk);
        alloc_vld <= 1'b1;
        alloc_pld <= p;
        do begin
            @(posedge clk);
        end while (!alloc_rdy);
        alloc_vld <= 1'b0;

        // older entries release one per cycle, lowest first
        pend = rows[r].hzd_pass ? '0 : rows[r].hzd_bitmap;
        cyc  = 0;
        do begin
            if (cyc >= int'(rows[r].rel_cycle) && pend != '0) begin
                low = pend & -pend;
                pend = pend & ~low;
                v_release_en <= low;
            end else begin
                v_release_en <= '0;
            end
            @(posedge clk);
            cyc++;
            if (alloc_rdy) begin
                report_problem("alloc_rdy rose before release_en");
            end
            if (!entry_active) begin
                report_problem("entry_active low while the miss is in flight");
            end
        end while (!release_en);
        v_release_en <= '0;
        @(posedge clk);
        if (!alloc_rdy) begin
            report_problem("alloc_rdy not high the cycle after release_en");
        end
        if (entry_active) begin
            report_problem("entry_active still high the cycle after release_en");
        end
        if (release_en) begin
            report_problem("release_en lasted more than one cycle");
        end
        if (n_evict != int'(rows[r].exp_evict)) begin
            report_mismatch("evict beats", int'(rows[r].exp_evict), n_evict);
        end
        if (n_fill != int'(rows[r].exp_fill)) begin
            report_mismatch("linefill requests", int'(rows[r].exp_fill), n_fill);
        end
        if (n_access != int'(rows[r].exp_access)) begin
            report_mismatch("access requests", int'(rows[r].exp_access), n_access);
        end
        exp_db = rows[r].is_write ? rows[r].wdb_id : {rows[r].alloc_idx, 2'b00};
        if (access_op != int'(rows[r].exp_op)) begin
            report_mismatch("access opcode", int'(rows[r].exp_op), access_op);
        end
        if (access_db != int'(exp_db)) begin
            report_mismatch("access buffer id", int'(exp_db), access_db);
        end
    endtask

    // ====================
    // main sequence
    // ====================
    initial begin
        int n_pass;
        int errs_before;

        n_pass = 0;
        load_table();
        rst_n        <= 1'b0;
        alloc_vld    <= 1'b0;
        alloc_pld    <= '0;
        v_release_en <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        if (!alloc_rdy || entry_active || release_en ||
            evict_vld || ds_req_vld || dataram_vld) begin
            report_problem("entry not idle after reset");
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            errs_before = err_count;
            run_row(r);
            if (err_count == errs_before) begin
                n_pass++;
                $display("test %-14s passed", names[r]);
            end else begin
                $display("test %-14s failed with %0d errors", names[r], err_count - errs_before);
            end
        end
        cur_name = "summary";
        if (n_release != NUM_ROWS) begin
            report_mismatch("release pulses", NUM_ROWS, n_release);
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 NUM_ROWS, n_pass, NUM_ROWS - n_pass, err_count);
        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // watchdog sized from the table
    initial begin
        repeat (RESET_CYCLES + NUM_ROWS * ROW_CYCLES) @(posedge clk);
        $display("timeout: run exceeded %0d cycles", RESET_CYCLES + NUM_ROWS * ROW_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/mshr_entry_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module mshr_entry_assert
    import mshr_pkg::*;
(
    input logic         clk,
    input logic         rst_n,
    input logic         evict_vld,
    input logic         evict_rdy,
    input dataram_req_t evict_pld,
    input logic         ds_req_vld,
    input logic         ds_req_rdy,
    input ds_req_t      ds_req_pld,
    input logic         dataram_vld,
    input logic         dataram_rdy,
    input dataram_req_t dataram_pld,
    input logic         release_en,
    input logic         entry_active
);

    // ====================
    // handshake hold
    // ====================
    evict_hold: assert property (@(posedge clk) disable iff (!rst_n)
        evict_vld && !evict_rdy |=> evict_vld && $stable(evict_pld))
        else $error("evict valid or payload changed while stalled");

    linefill_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ds_req_vld && !ds_req_rdy |=> ds_req_vld && $stable(ds_req_pld))
        else $error("linefill valid or payload changed while stalled");

    access_hold: assert property (@(posedge clk) disable iff (!rst_n)
        dataram_vld && !dataram_rdy |=> dataram_vld && $stable(dataram_pld))
        else $error("access valid or payload changed while stalled");

    // ====================
    // ordering
    // ====================
    release_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        release_en |=> !release_en)
        else $error("release_en held for more than one cycle");

    // phases run strictly one after another
    one_phase: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({evict_vld, ds_req_vld, dataram_vld}))
        else $error("more than one phase request valid at once");

    busy_only: assert property (@(posedge clk) disable iff (!rst_n)
        (evict_vld || ds_req_vld || dataram_vld || release_en) |-> entry_active)
        else $error("request or release from an idle entry");

endmodule

bind mshr_entry_top mshr_entry_assert u_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .evict_vld    (evict_vld),
    .evict_rdy    (evict_rdy),
    .evict_pld    (evict_pld),
    .ds_req_vld   (ds_req_vld),
    .ds_req_rdy   (ds_req_rdy),
    .ds_req_pld   (ds_req_pld),
    .dataram_vld  (dataram_vld),
    .dataram_rdy  (dataram_rdy),
    .dataram_pld  (dataram_pld),
    .release_en   (release_en),
    .entry_active (entry_active)
);

`default_nettype wire

// ==== source/mshr_entry_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mshr_macros.svh"

module mshr_entry_top
    import mshr_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,

    // allocation
    input  logic                       alloc_vld,
    output logic                       alloc_rdy,
    input  mshr_alloc_t                alloc_pld,

    // release and status
    input  logic [`MSHR_ENTRY_NUM-1:0] v_release_en,
    output logic                       release_en,
    output logic                       entry_active,

    // evict read into the evict data buffer
    output logic                       evict_vld,
    input  logic                       evict_rdy,
    output dataram_req_t               evict_pld,
    input  logic                       evict_clean,

    // linefill request to downstream memory
    output logic                       ds_req_vld,
    input  logic                       ds_req_rdy,
    output ds_req_t                    ds_req_pld,
    input  logic                       linefill_done,

    // data ram access
    output logic                       dataram_vld,
    input  logic                       dataram_rdy,
    output dataram_req_t               dataram_pld,
    input  logic                       access_done
);

    mshr_alloc_t                      ctx;
    logic                             start;
    logic                             evict_finish;
    logic                             linefill_finish;
    logic [$clog2(`EVICT_BEATS)-1:0]  evict_beat;
    dataram_req_t                     evict_beat_pld;
    ds_req_t                          ds_pld;
    dataram_req_t                     access_pld;
    logic                             access_needed;

    mshr_alloc_ctrl u_alloc_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc_vld    (alloc_vld),
        .alloc_rdy    (alloc_rdy),
        .alloc_pld    (alloc_pld),
        .v_release_en (v_release_en),
        .release_en   (release_en),
        .ctx          (ctx),
        .start        (start),
        .entry_active (entry_active)
    );

    mshr_req_build u_req_build (
        .ctx           (ctx),
        .evict_beat    (evict_beat),
        .evict_pld     (evict_beat_pld),
        .ds_pld        (ds_pld),
        .access_pld    (access_pld),
        .access_needed (access_needed)
    );

    // ====================
    // phase chain
    // ====================
    mshr_phase_issuer #(
        .pld_t     (dataram_req_t),
        .NUM_BEATS (`EVICT_BEATS)
    ) u_evict_stage (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .needed  (ctx.need_evict),
        .pld     (evict_beat_pld),
        .beat    (evict_beat),
        .req_vld (evict_vld),
        .req_rdy (evict_rdy),
        .req_pld (evict_pld),
        .done    (evict_clean),
        .finish  (evict_finish)
    );

    mshr_phase_issuer #(
        .pld_t     (ds_req_t),
        .NUM_BEATS (1)
    ) u_linefill_stage (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (evict_finish),
        .needed  (ctx.need_linefill),
        .pld     (ds_pld),
        .beat    (),
        .req_vld (ds_req_vld),
        .req_rdy (ds_req_rdy),
        .req_pld (ds_req_pld),
        .done    (linefill_done),
        .finish  (linefill_finish)
    );

    // its finish token is the entry release
    mshr_phase_issuer #(
        .pld_t     (dataram_req_t),
        .NUM_BEATS (1)
    ) u_access_stage (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (linefill_finish),
        .needed  (access_needed),
        .pld     (access_pld),
        .beat    (),
        .req_vld (dataram_vld),
        .req_rdy (dataram_rdy),
        .req_pld (dataram_pld),
        .done    (access_done),
        .finish  (release_en)
    );

endmodule

`default_nettype wire

// ==== source/mshr_req_build.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mshr_macros.svh"

module mshr_req_build
    import mshr_pkg::*;
(
    input  mshr_alloc_t                      ctx,
    input  logic [$clog2(`EVICT_BEATS)-1:0]  evict_beat,
    output dataram_req_t                     evict_pld,
    output ds_req_t                          ds_pld,
    output dataram_req_t                     access_pld,
    output logic                             access_needed
);

    logic [`DEST_RAM_BITS-1:0] dest_ram_id;
    logic [`DB_ID_WIDTH-1:0]   entry_db_id;

    // hash id in the top 2 bits, then the ram select
    assign dest_ram_id = ctx.tag[`TAG_WIDTH-1 -: `DEST_RAM_BITS];

    // linefill and read buffers are owned by this entry
    assign entry_db_id = {ctx.alloc_idx, 2'b00};

    // ====================
    // evict beats
    // ====================
    always_comb begin
        evict_pld.txnid          = ctx.txnid;
        evict_pld.txnid.byte_sel = evict_beat;
        evict_pld.opcode         = `OP_EVICT;
        evict_pld.tag            = ctx.tag;
        evict_pld.index          = ctx.index;
        evict_pld.offset         = ctx.offset;
        evict_pld.way            = ctx.way;
        evict_pld.dest_ram_id    = dest_ram_id;
        evict_pld.rob_entry_id   = ctx.alloc_idx;
        evict_pld.db_entry_id    = {ctx.alloc_idx, evict_beat};
        evict_pld.sideband       = ctx.sideband;
        evict_pld.last           = (evict_beat == 2'(`EVICT_BEATS - 1));
    end

    // ====================
    // downstream linefill
    // ====================
    always_comb begin
        ds_pld.txnid        = ctx.txnid;
        ds_pld.addr.tag     = ctx.tag;
        ds_pld.addr.index   = ctx.index;
        ds_pld.addr.offset  = ctx.offset;
        ds_pld.way          = ctx.way;
        ds_pld.dest_ram_id  = dest_ram_id;
        ds_pld.db_entry_id  = entry_db_id;
        ds_pld.rob_entry_id = ctx.alloc_idx;
        ds_pld.sideband     = ctx.sideband;
    end

    // read or write, direction rides in txnid
    always_comb begin
        access_pld.txnid        = ctx.txnid;
        access_pld.opcode       = ctx.is_write ? `OP_WRITE : `OP_READ;
        access_pld.tag          = ctx.tag;
        access_pld.index        = ctx.index;
        access_pld.offset       = ctx.offset;
        access_pld.way          = ctx.way;
        access_pld.dest_ram_id  = dest_ram_id;
        access_pld.rob_entry_id = ctx.alloc_idx;
        access_pld.db_entry_id  = ctx.is_write ? ctx.wdb_entry_id : entry_db_id;
        access_pld.sideband     = ctx.sideband;
        access_pld.last         = 1'b1;
    end

    assign access_needed = ctx.is_read | ctx.is_write;

endmodule

`default_nettype wire

// ==== source/mshr_phase_issuer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mshr_macros.svh"

module mshr_phase_issuer
    import mshr_pkg::*;
#(
    parameter type pld_t     = dataram_req_t,
    parameter int  NUM_BEATS = 1,
    localparam int BEAT_W    = (NUM_BEATS > 1) ? $clog2(NUM_BEATS) : 1
) (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              start,
    input  logic              needed,
    input  pld_t              pld,
    output logic [BEAT_W-1:0] beat,

    output logic              req_vld,
    input  logic              req_rdy,
    output pld_t              req_pld,

    input  logic              done,
    output logic              finish
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_WAIT
    } state_e;

    state_e            state;
    logic [BEAT_W-1:0] beat_q;
    logic              xfer;
    logic              last_beat;
    logic              finish_q;

    assign xfer      = req_vld && req_rdy;
    assign last_beat = (beat_q == BEAT_W'(NUM_BEATS - 1));

    // payload tracks the beat, so it holds while the beat does
    assign req_vld = (state == ST_SEND);
    assign req_pld = pld;
    assign beat    = beat_q;
    assign finish  = finish_q;

    // ====================
    // phase FSM
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start && needed) begin
                        state <= ST_SEND;
                    end
                end
                ST_SEND: begin
                    if (xfer && last_beat) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (done) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // beat counter restarts with each burst
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_q <= '0;
        end else if (start) begin
            beat_q <= '0;
        end else if (xfer && !last_beat) begin
            beat_q <= beat_q + 1'b1;
        end
    end

    // skipped phase passes the token straight on
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            finish_q <= 1'b0;
        end else begin
            finish_q <= (state == ST_IDLE && start && !needed) ||
                        (state == ST_WAIT && done);
        end
    end

endmodule

`default_nettype wire

// ==== source/mshr_alloc_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mshr_macros.svh"

module mshr_alloc_ctrl
    import mshr_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic                       alloc_vld,
    output logic                       alloc_rdy,
    input  mshr_alloc_t                alloc_pld,

    input  logic [`MSHR_ENTRY_NUM-1:0] v_release_en,
    input  logic                       release_en,

    output mshr_alloc_t                ctx,
    output logic                       start,
    output logic                       entry_active
);

    logic                       idle;
    logic                       alloc_fire;
    logic                       waiting;
    logic                       hzd_clear;
    logic                       start_q;
    logic [`MSHR_ENTRY_NUM-1:0] keep_bitmap;
    mshr_alloc_t                ctx_q;

    assign alloc_fire   = alloc_vld && alloc_rdy;
    assign alloc_rdy    = idle;
    assign entry_active = ~idle;
    assign ctx          = ctx_q;
    assign start        = start_q;

    // ====================
    // occupancy
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idle <= 1'b1;
        end else if (alloc_fire) begin
            idle <= 1'b0;
        end else if (release_en) begin
            idle <= 1'b1;
        end
    end

    // request context, held for the life of the miss
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            ctx_q <= alloc_pld;
        end
    end

    // ====================
    // hazard wait
    // ====================
    // older entries drop out of the bitmap as they release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            keep_bitmap <= '0;
        end else if (alloc_fire) begin
            keep_bitmap <= alloc_pld.hzd_bitmap;
        end else begin
            keep_bitmap <= keep_bitmap & ~v_release_en;
        end
    end

    assign hzd_clear = ~|keep_bitmap;

    // set while the entry still owes its start token
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            waiting <= 1'b0;
        end else if (alloc_fire) begin
            waiting <= ~alloc_pld.hzd_pass;
        end else if (waiting && hzd_clear) begin
            waiting <= 1'b0;
        end
    end

    // single pulse, either straight after allocation or once the bitmap drains
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_q <= 1'b0;
        end else begin
            start_q <= (alloc_fire && alloc_pld.hzd_pass) || (waiting && hzd_clear);
        end
    end

endmodule

`default_nettype wire

// ==== source/mshr_pkg.sv ====
`default_nettype none

`include "mshr_macros.svh"

package mshr_pkg;

    // direction 00 west, 01 east, 10 south, 11 north
    typedef struct packed {
        logic [`DIR_WIDTH-1:0]       direction_id;
        logic [`MASTER_ID_WIDTH-1:0] master_id;
        logic [`MODE_WIDTH-1:0]      mode;
        logic [`BYTE_SEL_WIDTH-1:0]  byte_sel;
    } txnid_t;

    typedef struct packed {
        logic [`TAG_WIDTH-1:0]    tag;
        logic [`INDEX_WIDTH-1:0]  index;
        logic [`OFFSET_WIDTH-1:0] offset;
    } addr_t;

    // ====================
    // allocation context
    // ====================
    typedef struct packed {
        txnid_t                      txnid;
        logic [`TAG_WIDTH-1:0]       tag;
        logic [`INDEX_WIDTH-1:0]     index;
        logic [`OFFSET_WIDTH-1:0]    offset;
        logic [`WAY_WIDTH-1:0]       way;
        logic [`ALLOC_IDX_WIDTH-1:0] alloc_idx;
        logic [`DB_ID_WIDTH-1:0]     wdb_entry_id;
        logic [`SIDEBAND_WIDTH-1:0]  sideband;
        logic                        hit;
        logic                        need_evict;
        logic                        need_linefill;
        logic                        is_read;
        logic                        is_write;
        logic                        hzd_pass;
        logic [`MSHR_ENTRY_NUM-1:0]  hzd_bitmap;
    } mshr_alloc_t;

    // evict beats and accesses share this one
    typedef struct packed {
        txnid_t                      txnid;
        logic [`OPCODE_WIDTH-1:0]    opcode;
        logic [`TAG_WIDTH-1:0]       tag;
        logic [`INDEX_WIDTH-1:0]     index;
        logic [`OFFSET_WIDTH-1:0]    offset;
        logic [`WAY_WIDTH-1:0]       way;
        logic [`DEST_RAM_BITS-1:0]   dest_ram_id;
        logic [`ALLOC_IDX_WIDTH-1:0] rob_entry_id;
        logic [`DB_ID_WIDTH-1:0]     db_entry_id;
        logic [`SIDEBAND_WIDTH-1:0]  sideband;
        logic                        last;
    } dataram_req_t;

    typedef struct packed {
        txnid_t                      txnid;
        addr_t                       addr;
        logic [`WAY_WIDTH-1:0]       way;
        logic [`DEST_RAM_BITS-1:0]   dest_ram_id;
        logic [`DB_ID_WIDTH-1:0]     db_entry_id;
        logic [`ALLOC_IDX_WIDTH-1:0] rob_entry_id;
        logic [`SIDEBAND_WIDTH-1:0]  sideband;
    } ds_req_t;

endpackage

`default_nettype wire

// ==== source/mshr_macros.svh ====
`ifndef MSHR_MACROS_SVH
`define MSHR_MACROS_SVH

// ====================
// entry counts
// ====================
`define MSHR_ENTRY_NUM      8
`define ALLOC_IDX_WIDTH     3

// address split of a request
`define TAG_WIDTH           20
`define INDEX_WIDTH         8
`define OFFSET_WIDTH        2
`define WAY_WIDTH           3

// top tag bits pick hash, block and ram
`define DEST_RAM_BITS       5

// evict burst, one beat per quarter line
`define EVICT_BEATS         4

// entry index in the high bits, beat in the low two
`define DB_ID_WIDTH         5

`define SIDEBAND_WIDTH      8

// transaction id fields
`define DIR_WIDTH           2
`define MASTER_ID_WIDTH     4
`define MODE_WIDTH          2
`define BYTE_SEL_WIDTH      2

// ====================
// opcodes
// ====================
`define OPCODE_WIDTH        2
`define OP_READ             2'd0
`define OP_WRITE            2'd1
`define OP_EVICT            2'd2
`define OP_LINEFILL         2'd3

`endif
